/* flist.f */
hdl/isa_pkg.sv
hdl/cdb_pkg.sv
hdl/int_issue_queue.sv
hdl/int_alu.sv
hdl/exec_cluster.sv
hdl/cdb_arbiter.sv
hdl/issue_top.sv
tests/issue_top_checker.sv
tests/issue_top_tb.sv

/* hdl/cdb_arbiter.sv */
// round-robin arbiter putting one of two cluster results on the CDB
module cdb_arbiter (
   input  logic             clk,
   input  logic             rst_n,
   input  cdb_pkg::result_t result0,
   input  logic             result_valid0,
   input  cdb_pkg::result_t result1,
   input  logic             result_valid1,
   output logic             grant0,
   output logic             grant1,
   output cdb_pkg::cdb_t    cdb
);

   // which cluster wins the next conflict
   typedef enum logic {
      prefer_0 = 1'b0,
      prefer_1 = 1'b1
   } rr_state_t;

   rr_state_t rr_q;

   // a lone request always wins, a conflict goes to the preferred side
   assign grant0 = result_valid0 & (~result_valid1 | (rr_q == prefer_0));
   assign grant1 = result_valid1 & (~result_valid0 | (rr_q == prefer_1));

   // the pointer flips only after a cycle in which both competed
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rr_q <= prefer_0;
      end else if (result_valid0 && result_valid1) begin
         rr_q <= (rr_q == prefer_0) ? prefer_1 : prefer_0;
      end
   end

   always_comb begin
      cdb.valid = grant0 | grant1;
      if (grant1) begin
         cdb.tag  = result1.tag;
         cdb.data = result1.data;
      end else begin
         cdb.tag  = result0.tag;
         cdb.data = result0.data;
      end
   end

endmodule

/* hdl/cdb_pkg.sv */
// result-side definitions for the ALU outputs and the common data bus
package cdb_pkg;

   // finished result waiting in an ALU result buffer
   typedef struct packed {
      isa_pkg::tag_t  tag;
      isa_pkg::word_t data;
   } result_t;

   // common data bus, seen by every issue queue
   typedef struct packed {
      logic           valid;
      isa_pkg::tag_t  tag;
      isa_pkg::word_t data;
   } cdb_t;

endpackage

/* hdl/exec_cluster.sv */
// one execution lane, an issue queue feeding one ALU
// the issue handshake stays inside the cluster
module exec_cluster #(
   parameter int QUEUE_DEPTH = 4
) (
   input  logic               clk,
   input  logic               rst_n,
   input  isa_pkg::dispatch_t disp,
   input  logic               dispatch_en,
   input  cdb_pkg::cdb_t      cdb,
   input  logic               result_grant,
   output logic               dispatch_ready,
   output cdb_pkg::result_t   result,
   output logic               result_valid
);

   isa_pkg::issue_t issue;
   logic            issue_ready;
   logic            issue_done;

   int_issue_queue #(
      .QUEUE_DEPTH(QUEUE_DEPTH)
   ) u_queue (
      .clk            (clk),
      .rst_n          (rst_n),
      .disp           (disp),
      .dispatch_en    (dispatch_en),
      .cdb            (cdb),
      .issue_done     (issue_done),
      .dispatch_ready (dispatch_ready),
      .issue          (issue),
      .issue_ready    (issue_ready)
   );

   int_alu u_alu (
      .clk          (clk),
      .rst_n        (rst_n),
      .issue        (issue),
      .issue_ready  (issue_ready),
      .result_grant (result_grant),
      .issue_done   (issue_done),
      .result       (result),
      .result_valid (result_valid)
   );

endmodule

/* hdl/int_alu.sv */
// single-cycle integer ALU with a one-entry result buffer
// the buffer holds its result until the CDB arbiter grants it
module int_alu (
   input  logic              clk,
   input  logic              rst_n,
   input  isa_pkg::issue_t   issue,
   input  logic              issue_ready,
   input  logic              result_grant,
   output logic              issue_done,
   output cdb_pkg::result_t  result,
   output logic              result_valid
);

   isa_pkg::word_t value;

   always_comb begin
      case (issue.opcode)
         isa_pkg::op_add: value = issue.rs_data + issue.rt_data;
         isa_pkg::op_sub: value = issue.rs_data - issue.rt_data;
         isa_pkg::op_and: value = issue.rs_data & issue.rt_data;
         isa_pkg::op_or:  value = issue.rs_data | issue.rt_data;
         isa_pkg::op_xor: value = issue.rs_data ^ issue.rt_data;
         isa_pkg::op_sll: value = issue.rs_data << issue.rt_data[4:0];
         isa_pkg::op_srl: value = issue.rs_data >> issue.rt_data[4:0];
         isa_pkg::op_slt: begin
            value = {31'b0, $signed(issue.rs_data) < $signed(issue.rt_data)};
         end
         default:         value = '0;
      endcase
   end

   // accept only when the buffer is empty or drains in this same cycle
   assign issue_done = issue_ready & (~result_valid | result_grant);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         result_valid <= 1'b0;
      end else if (issue_done) begin
         result_valid <= 1'b1;
      end else if (result_grant) begin
         result_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (issue_done) begin
         result.tag  <= issue.rd_tag;
         result.data <= value;
      end
   end

endmodule

/* hdl/int_issue_queue.sv */
// shifting issue queue for integer instructions
// slot 0 holds the oldest entry and new entries enter at the top slot
module int_issue_queue #(
   parameter int QUEUE_DEPTH = 4
) (
   input  logic               clk,
   input  logic               rst_n,
   input  isa_pkg::dispatch_t disp,
   input  logic               dispatch_en,
   input  cdb_pkg::cdb_t      cdb,
   input  logic               issue_done,
   output logic               dispatch_ready,
   output isa_pkg::issue_t    issue,
   output logic               issue_ready
);

   // stored entries and their occupancy
   isa_pkg::dispatch_t     slot_q [QUEUE_DEPTH];
   logic [QUEUE_DEPTH-1:0] busy_q;

   // entries after the CDB wakeup, index QUEUE_DEPTH is the incoming dispatch
   isa_pkg::dispatch_t     woken [QUEUE_DEPTH+1];
   logic [QUEUE_DEPTH:0]   busy_in;

   logic [QUEUE_DEPTH-1:0] ready;
   logic [QUEUE_DEPTH-1:0] sel;
   logic [QUEUE_DEPTH-1:0] gap;
   logic [QUEUE_DEPTH-1:0] shift;

   // a pending operand whose tag is on the CDB takes the bus data
   // operands that are already valid are left alone
   function automatic isa_pkg::dispatch_t wake(input isa_pkg::dispatch_t e,
                                               input cdb_pkg::cdb_t      bus);
      isa_pkg::dispatch_t w;
      w = e;
      if (bus.valid && !e.rs_valid && bus.tag == e.rs_tag) begin
         w.rs_valid = 1'b1;
         w.rs_data  = bus.data;
      end
      if (bus.valid && !e.rt_valid && bus.tag == e.rt_tag) begin
         w.rt_valid = 1'b1;
         w.rt_data  = bus.data;
      end
      return w;
   endfunction

   function automatic isa_pkg::issue_t to_issue(input isa_pkg::dispatch_t e);
      isa_pkg::issue_t s;
      s.opcode  = e.opcode;
      s.rd_tag  = e.rd_tag;
      s.rs_data = e.rs_data;
      s.rt_data = e.rt_data;
      return s;
   endfunction

   // the incoming entry is compared against the CDB too, so a result
   // broadcast in its dispatch cycle is not missed
   // the entry that issues this cycle is no longer occupied when it moves down
   always_comb begin
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         woken[i]   = wake(slot_q[i], cdb);
         busy_in[i] = busy_q[i] & ~(sel[i] & issue_done);
      end
      woken[QUEUE_DEPTH]   = wake(disp, cdb);
      busy_in[QUEUE_DEPTH] = dispatch_en;
   end

   // readiness looks at the stored operands only
   // a wakeup in this cycle allows issue from the next edge on
   always_comb begin
      logic found;
      found = 1'b0;
      sel   = '0;
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         ready[i] = busy_q[i] & slot_q[i].rs_valid & slot_q[i].rt_valid;
         if (ready[i] && !found) begin
            sel[i] = 1'b1;
            found  = 1'b1;
         end
      end
   end

   // oldest ready entry goes to the ALU, slot 0 is shown when none is ready
   always_comb begin
      issue = to_issue(slot_q[0]);
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         if (sel[i]) begin
            issue = to_issue(slot_q[i]);
         end
      end
   end

   assign issue_ready = |ready;

   // a slot is free when it is empty or its entry leaves this cycle
   // every slot at or above the lowest free slot moves down by one
   always_comb begin
      logic below;
      below = 1'b0;
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         gap[i]   = ~busy_q[i] | (sel[i] & issue_done);
         shift[i] = gap[i] | below;
         below    = shift[i];
      end
   end

   // the top slot can take a new entry whenever anything moves down
   assign dispatch_ready = shift[QUEUE_DEPTH-1];

   always_ff @(posedge clk) begin
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         if (shift[i]) begin
            slot_q[i] <= woken[i+1];
         end else begin
            slot_q[i] <= woken[i];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy_q <= '0;
      end else begin
         for (int i = 0; i < QUEUE_DEPTH; i++) begin
            busy_q[i] <= shift[i] ? busy_in[i+1] : busy_in[i];
         end
      end
   end

endmodule

/* hdl/isa_pkg.sv */
// instruction-side definitions shared by the dispatch, issue queue and ALU
package isa_pkg;

   // rename tag of the producing instruction, tag 0 means no producer
   typedef logic [5:0] tag_t;

   // integer data word
   typedef logic [31:0] word_t;

   // operand a is rs and operand b is rt for every opcode
   typedef enum logic [2:0] {
      op_add = 3'd0,
      op_sub = 3'd1,
      op_and = 3'd2,
      op_or  = 3'd3,
      op_xor = 3'd4,
      op_sll = 3'd5,
      op_srl = 3'd6,
      op_slt = 3'd7
   } alu_op_t;

   // renamed instruction as handed over by the dispatch unit
   // an operand that is already valid carries tag 0
   typedef struct packed {
      alu_op_t opcode;
      tag_t    rd_tag;
      tag_t    rs_tag;
      tag_t    rt_tag;
      word_t   rs_data;
      word_t   rt_data;
      logic    rs_valid;
      logic    rt_valid;
   } dispatch_t;

   // instruction with both operands resolved, sent from queue to ALU
   typedef struct packed {
      alu_op_t opcode;
      tag_t    rd_tag;
      word_t   rs_data;
      word_t   rt_data;
   } issue_t;

endpackage

/* hdl/issue_top.sv */
// out-of-order integer back end with two execution clusters sharing one CDB
module issue_top #(
   parameter int QUEUE_DEPTH = 4
) (
   input  logic               clk,
   input  logic               rst_n,
   input  isa_pkg::dispatch_t disp0,
   input  logic               dispatch_en0,
   input  isa_pkg::dispatch_t disp1,
   input  logic               dispatch_en1,
   output logic               dispatch_ready0,
   output logic               dispatch_ready1,
   output cdb_pkg::cdb_t      cdb
);

   cdb_pkg::result_t result0;
   cdb_pkg::result_t result1;
   logic             result_valid0;
   logic             result_valid1;
   logic             grant0;
   logic             grant1;

   exec_cluster #(
      .QUEUE_DEPTH(QUEUE_DEPTH)
   ) u_cluster0 (
      .clk            (clk),
      .rst_n          (rst_n),
      .disp           (disp0),
      .dispatch_en    (dispatch_en0),
      .cdb            (cdb),
      .result_grant   (grant0),
      .dispatch_ready (dispatch_ready0),
      .result         (result0),
      .result_valid   (result_valid0)
   );

   exec_cluster #(
      .QUEUE_DEPTH(QUEUE_DEPTH)
   ) u_cluster1 (
      .clk            (clk),
      .rst_n          (rst_n),
      .disp           (disp1),
      .dispatch_en    (dispatch_en1),
      .cdb            (cdb),
      .result_grant   (grant1),
      .dispatch_ready (dispatch_ready1),
      .result         (result1),
      .result_valid   (result_valid1)
   );

   cdb_arbiter u_arbiter (
      .clk           (clk),
      .rst_n         (rst_n),
      .result0       (result0),
      .result_valid0 (result_valid0),
      .result1       (result1),
      .result_valid1 (result_valid1),
      .grant0        (grant0),
      .grant1        (grant1),
      .cdb           (cdb)
   );

endmodule

/* run.sh */
#!/bin/sh
# build with Verilator, run, then scan the log for the fail message
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --assert --top-module issue_top_tb -f flist.f -o issue_top_sim &&
( ./obj_dir/issue_top_sim > sim.log 2>&1 || true ) &&
cat sim.log &&
! grep -q "Test failed" sim.log &&
grep -q "Test passed" sim.log ||
{ echo "simulation failed"; exit 1; }

/* tests/issue_top_checker.sv */
// assertions on the CDB and the arbiter grants inside issue_top
module issue_top_checker (
   input logic          clk,
   input logic          rst_n,
   input cdb_pkg::cdb_t cdb,
   input logic          grant0,
   input logic          grant1
);

   // tag 0 stands for no producer and is never broadcast
   cdb_no_null_tag: assert property (
      @(posedge clk) disable iff (!rst_n) cdb.valid |-> cdb.tag != '0
   ) else $error("cdb broadcast tag 0");

   // at most one cluster owns the CDB in a cycle
   single_grant: assert property (
      @(posedge clk) disable iff (!rst_n) !(grant0 && grant1)
   ) else $error("both clusters granted the cdb");

   // nothing can have finished in the first cycle out of reset
   quiet_after_reset: assert property (
      @(posedge clk) $rose(rst_n) |-> !cdb.valid
   ) else $error("cdb valid in the first cycle after reset");

endmodule

bind issue_top issue_top_checker u_checker (
   .clk    (clk),
   .rst_n  (rst_n),
   .cdb    (cdb),
   .grant0 (grant0),
   .grant1 (grant1)
);

/* tests/issue_top_tb.sv */
// testbench for issue_top, table driven dispatch with a scoreboard on the CDB
module issue_top_tb;

   localparam int QUEUE_DEPTH = 4;

   // one stimulus row
   // pair sends the row together with the next one on the other port
   // drain waits for every open result before the next test starts
   typedef struct packed {
      int                 test;
      logic               port;
      isa_pkg::dispatch_t ins;
      logic               pair;
      int                 delay;
      logic               drain;
   } row_t;

   logic               clk;
   logic               rst_n;
   isa_pkg::dispatch_t disp0;
   logic               dispatch_en0;
   isa_pkg::dispatch_t disp1;
   logic               dispatch_en1;
   logic               dispatch_ready0;
   logic               dispatch_ready1;
   cdb_pkg::cdb_t      cdb;

   row_t               table_q [$];
   isa_pkg::dispatch_t sent [64];
   bit                 outstanding [64];
   bit                 produced [64];
   isa_pkg::word_t     produced_val [64];
   int                 open_count = 0;
   int                 errors = 0;
   int                 checks = 0;
   int                 tests = 0;
   int                 stalls = 0;
   int                 seed = 32'h2caf;
   bit                 built = 1'b0;

   issue_top #(
      .QUEUE_DEPTH(QUEUE_DEPTH)
   ) issue_top_inst (
      .clk             (clk),
      .rst_n           (rst_n),
      .disp0           (disp0),
      .dispatch_en0    (dispatch_en0),
      .disp1           (disp1),
      .dispatch_en1    (dispatch_en1),
      .dispatch_ready0 (dispatch_ready0),
      .dispatch_ready1 (dispatch_ready1),
      .cdb             (cdb)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // result of each opcode with a as rs and b as rt
   function automatic isa_pkg::word_t expect_value(input isa_pkg::alu_op_t op,
                                                   input isa_pkg::word_t a,
                                                   input isa_pkg::word_t b);
      case (op)
         isa_pkg::op_add: return a + b;
         isa_pkg::op_sub: return a - b;
         isa_pkg::op_and: return a & b;
         isa_pkg::op_or:  return a | b;
         isa_pkg::op_xor: return a ^ b;
         isa_pkg::op_sll: return a << b[4:0];
         isa_pkg::op_srl: return a >> b[4:0];
         isa_pkg::op_slt: begin
            // with different signs the negative one is smaller
            if (a[31] != b[31]) return {31'b0, a[31]};
            return {31'b0, a < b};
         end
         default:         return '0;
      endcase
   endfunction

   // rt is always an immediate, rs waits on rs_tag unless that is 0
   task automatic add_row(input int test, input bit port, input isa_pkg::alu_op_t op,
                          input int rd, input int rs_tag, input isa_pkg::word_t a,
                          input isa_pkg::word_t b, input bit pair, input int delay,
                          input bit drain);
      row_t r;
      r = '0;
      r.test           = test;
      r.port           = port;
      r.ins.opcode     = op;
      r.ins.rd_tag     = isa_pkg::tag_t'(rd);
      r.ins.rs_tag     = isa_pkg::tag_t'(rs_tag);
      r.ins.rs_data    = a;
      r.ins.rs_valid   = (rs_tag == 0);
      r.ins.rt_data    = b;
      r.ins.rt_valid   = 1'b1;
      r.pair           = pair;
      r.delay          = delay;
      r.drain          = drain;
      table_q.push_back(r);
   endtask

   task automatic build_table();
      int k;
      int rnd;
      for (k = 0; k < 8; k++) begin
         add_row(2, 0, isa_pkg::alu_op_t'(k), 1 + 2 * k, 0, $random(seed), $random(seed),
                 1, 0, 0);
         add_row(2, 1, isa_pkg::alu_op_t'(k), 2 + 2 * k, 0, $random(seed), $random(seed),
                 0, 0, k == 7);
      end
      // the delayed rows reach the queue while their producer is on the CDB
      add_row(3, 0, isa_pkg::op_add, 20, 0, 5, 7, 0, 0, 0);
      add_row(3, 1, isa_pkg::op_sub, 21, 20, 0, 2, 0, 1, 0);
      add_row(3, 0, isa_pkg::op_xor, 22, 21, 0, 32'hff, 0, 0, 0);
      add_row(3, 1, isa_pkg::op_sll, 23, 22, 0, 3, 0, 1, 0);
      add_row(3, 0, isa_pkg::op_slt, 24, 23, 0, 100, 0, 0, 1);
      for (k = 0; k < QUEUE_DEPTH; k++) begin
         add_row(4, 0, isa_pkg::alu_op_t'(k), 30 + k, 40, 0, k + 1, 0, 0, 0);
      end
      add_row(4, 0, isa_pkg::op_xor, 29, 0, 32'h1234, 32'h00ff, 1, 0, 0);
      add_row(4, 1, isa_pkg::op_sub, 40, 0, 1000, 1, 0, 0, 1);
      for (k = 0; k < 24; k++) begin
         rnd = $random(seed);
         add_row(5, 0, isa_pkg::alu_op_t'(rnd[2:0]), 1 + 2 * k, 0, $random(seed),
                 $random(seed), 1, 0, 0);
         add_row(5, 1, isa_pkg::alu_op_t'(rnd[5:3]), 2 + 2 * k, 0, $random(seed),
                 $random(seed), 0, 0, k == 23);
      end
   endtask

   task automatic record(input isa_pkg::dispatch_t ins);
      sent[ins.rd_tag]        = ins;
      outstanding[ins.rd_tag] = 1'b1;
      open_count++;
   endtask

   task automatic check_result(input isa_pkg::tag_t tag, input isa_pkg::word_t data);
      isa_pkg::dispatch_t e;
      isa_pkg::word_t     a;
      isa_pkg::word_t     want;
      checks++;
      if (!outstanding[tag]) begin
         $display("cdb carried tag %0d while no instruction was waiting on it", tag);
         errors++;
      end else begin
         e = sent[tag];
         a = e.rs_data;
         // a pending source takes the value its producer was expected to return
         if (!e.rs_valid) begin
            if (!produced[e.rs_tag]) begin
               $display("tag %0d finished before its producer tag %0d", tag, e.rs_tag);
               errors++;
            end
            a = produced_val[e.rs_tag];
         end
         want = expect_value(e.opcode, a, e.rt_data);
         if (data != want) begin
            $display("mismatch cdb.data tag %0d expected %h actual %h", tag, want, data);
            errors++;
         end
         outstanding[tag]  = 1'b0;
         produced[tag]     = 1'b1;
         produced_val[tag] = want;
         open_count--;
      end
   endtask

   // holds each port until its row is taken, the other port may go earlier
   task automatic apply_rows(input int first, input int count);
      row_t               r;
      bit                 pend [2];
      bit                 take [2];
      isa_pkg::dispatch_t ins [2];
      int                 k;
      pend[0] = 1'b0;
      pend[1] = 1'b0;
      ins[0]  = '0;
      ins[1]  = '0;
      repeat (table_q[first].delay) begin
         @(posedge clk);
         #1;
      end
      for (k = 0; k < count; k++) begin
         r            = table_q[first + k];
         pend[r.port] = 1'b1;
         ins[r.port]  = r.ins;
      end
      disp0        = ins[0];
      disp1        = ins[1];
      dispatch_en0 = pend[0];
      dispatch_en1 = pend[1];
      while (pend[0] || pend[1]) begin
         take[0] = pend[0] && dispatch_ready0;
         take[1] = pend[1] && dispatch_ready1;
         if (pend[0] && !dispatch_ready0) stalls++;
         @(posedge clk);
         #1;
         for (k = 0; k < 2; k++) begin
            if (take[k]) begin
               record(ins[k]);
               pend[k] = 1'b0;
            end
         end
         dispatch_en0 = pend[0];
         dispatch_en1 = pend[1];
      end
   endtask

   task automatic finish_test(input int test);
      wait (open_count == 0);
      @(posedge clk);
      #1;
      if (test == 4 && stalls == 0) begin
         $display("port 0 never stalled while its queue was full");
         errors++;
      end
      $display("test %0d done, %0d errors so far", test, errors);
      stalls = 0;
      tests++;
   endtask

   // the CDB is combinational from registers, so mid-cycle it is settled
   always @(negedge clk) begin
      if (rst_n && cdb.valid) begin
         check_result(cdb.tag, cdb.data);
      end
   end

   initial begin
      wait (built);
      repeat (table_q.size() * 20) @(posedge clk);
      $display("watchdog expired with %0d results still open", open_count);
      $display("Test failed");
      $finish;
   end

   initial begin
      int i;
      int n;
      rst_n        = 1'b0;
      disp0        = '0;
      disp1        = '0;
      dispatch_en0 = 1'b0;
      dispatch_en1 = 1'b0;
      build_table();
      built = 1'b1;
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;
      repeat (5) begin
         @(negedge clk);
         checks++;
         if (!dispatch_ready0 || !dispatch_ready1 || cdb.valid) begin
            $display("idle after reset shows ready %b%b and cdb valid %b",
                     dispatch_ready0, dispatch_ready1, cdb.valid);
            errors++;
         end
      end
      @(posedge clk);
      #1;
      $display("test 1 done, %0d errors so far", errors);
      tests++;
      i = 0;
      while (i < table_q.size()) begin
         n = 1;
         if (table_q[i].pair && i + 1 < table_q.size()) begin
            if (table_q[i + 1].port != table_q[i].port) n = 2;
         end
         apply_rows(i, n);
         i = i + n;
         if (table_q[i - 1].drain) finish_test(table_q[i - 1].test);
      end
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule
